/* rtl/ocl_dec_consts.svh */
/*
 * OCL decoder constants
 * Slot map, acknowledge timeout and the data word returned for
 * unmapped or timed-out reads
 */
`ifndef OCL_DEC_CONSTS_SVH
`define OCL_DEC_CONSTS_SVH

// Number of decoded 256-byte slots
`define OCL_NUM_SLOTS 4

// Lowest address bit of the slot number
`define OCL_SLOT_LSB 8

// Cycles to wait for a target acknowledge
`define OCL_ACK_TIMEOUT 16

// Read data for unmapped slots and timeouts
`define OCL_UNMAPPED_DATA 32'hdead_beef

`endif

/* rtl/ocl_axil_pkg.sv */
/*
 * AXI-Lite channel types
 * Payloads of the five AXI-Lite channels and the response code
 */
package ocl_axil_pkg;

  // Response codes, only the two the decoder returns
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axil_resp_t;

  // AW and AR payload
  typedef logic [31:0] axil_addr_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

  typedef struct packed {
    logic [31:0] data;
    axil_resp_t  resp;
  } axil_r_t;

endpackage

/* rtl/ocl_cfg_pkg.sv */
/*
 * Configuration bus types
 * Data words and byte enables of the configuration bus, plus the
 * states of the transaction state machine
 */
package ocl_cfg_pkg;

  // Data word on the configuration bus
  typedef logic [31:0] cfg_word_t;

  // One enable bit per byte lane
  typedef logic [3:0] cfg_strb_t;

  // ------------------------------
  // Decoder states
  // ------------------------------
  typedef enum logic [1:0] {
    SLV_IDLE    = 2'd0,
    SLV_WR_ADDR = 2'd1,
    SLV_CYC     = 2'd2,
    SLV_RESP    = 2'd3
  } slv_state_t;

endpackage

/* rtl/cfg_bus_if.sv */
/*
 * Configuration bus
 * One-cycle wr or rd strobe from the decoder, answered later by a
 * one-cycle ack from the register block with rdata valid alongside
 */
`timescale 1ns/1ps

interface cfg_bus_if;
  import ocl_axil_pkg::*;
  import ocl_cfg_pkg::*;

  axil_addr_t addr;
  cfg_word_t  wdata;
  cfg_strb_t  wstrb;
  logic       wr;
  logic       rd;
  logic       ack;
  cfg_word_t  rdata;

  // Decoder side
  modport master (
    output addr, wdata, wstrb, wr, rd,
    input  ack, rdata
  );

  // Register block side
  modport slave (
    input  addr, wdata, wstrb, wr, rd,
    output ack, rdata
  );

endinterface

/* rtl/axil_chan_slice.sv */
/*
 * AXI-Lite channel register slice
 * Two-entry skid buffer, registered on both sides, full throughput
 */
`timescale 1ns/1ps

module axil_chan_slice #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     sync_rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     skid_valid_nxt;
  logic     main_load;
  logic     in_xfer;

  // Main entry may take a new item when empty or draining
  assign main_load = out_ready || !out_valid;
  assign in_xfer   = in_valid && in_ready;

  always_comb
  begin
    skid_valid_nxt = skid_valid;
    if (main_load)
      skid_valid_nxt = 1'b0;
    else if (in_xfer)
      skid_valid_nxt = 1'b1;
  end

  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end
    else
    begin
      skid_valid <= skid_valid_nxt;
      in_ready   <= !skid_valid_nxt;
      if (main_load)
        out_valid <= skid_valid || in_xfer;
    end

  // Skid entry drains first, keeps order
  always_ff @(posedge clk)
  begin
    if (main_load)
      out_data <= skid_valid ? skid_data : in_data;
    if (!main_load && in_xfer)
      skid_data <= in_data;
  end

endmodule

/* rtl/ocl_slv_fsm.sv */
/*
 * OCL transaction state machine
 * Serves one AXI-Lite access at a time, write first. Decodes the slot
 * from the address, sends a single strobe on that slot's configuration
 * bus and builds the B or R response, with SLVERR on a timeout.
 */
`timescale 1ns/1ps
`include "ocl_dec_consts.svh"

module ocl_slv_fsm (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  logic                     flr,
  input  ocl_axil_pkg::axil_addr_t aw_addr,
  input  logic                     aw_valid,
  output logic                     aw_ready,
  input  ocl_axil_pkg::axil_w_t    w_data,
  input  logic                     w_valid,
  output logic                     w_ready,
  input  ocl_axil_pkg::axil_addr_t ar_addr,
  input  logic                     ar_valid,
  output logic                     ar_ready,
  output ocl_axil_pkg::axil_b_t    b_data,
  output logic                     b_valid,
  input  logic                     b_ready,
  output ocl_axil_pkg::axil_r_t    r_data,
  output logic                     r_valid,
  input  logic                     r_ready,
  output logic                     tmr_start,
  output logic                     tmr_clear,
  input  logic                     tmr_expired,
  cfg_bus_if.master                slot0,
  cfg_bus_if.master                slot1
);
  import ocl_axil_pkg::*;
  import ocl_cfg_pkg::*;

  localparam int NUM_MAPPED = 2;
  localparam int SEL_W      = 4;
  localparam int IDX_W      = $clog2(`OCL_NUM_SLOTS);

  slv_state_t            slv_state;
  slv_state_t            slv_state_nxt;
  logic                  slv_cyc_wr;
  axil_addr_t            slv_addr;
  logic [SEL_W-1:0]      slv_sel;
  logic [IDX_W-1:0]      slot_idx;
  logic                  sel_hit;
  logic                  req_valid;
  logic                  did_req;
  logic                  strobe_go;
  logic                  cyc_done;
  logic                  cyc_end;
  logic                  rsp_ready;
  logic [NUM_MAPPED-1:0] strb_wr;
  logic [NUM_MAPPED-1:0] strb_rd;
  logic [`OCL_NUM_SLOTS-1:0] slot_ack;
  cfg_word_t             slot_rdata [`OCL_NUM_SLOTS];
  logic                  tgt_ack;
  cfg_word_t             tgt_rdata;
  axil_resp_t            rsp_q;
  cfg_word_t             rdata_q;
  axil_addr_t            bus_addr;
  cfg_word_t             bus_wdata;
  cfg_strb_t             bus_wstrb;

  // ------------------------------
  // Decode
  // ------------------------------
  assign slv_sel   = slv_addr[`OCL_SLOT_LSB +: SEL_W];
  assign slot_idx  = slv_sel[IDX_W-1:0];
  assign sel_hit   = (slv_sel < `OCL_NUM_SLOTS);
  assign req_valid = slv_cyc_wr ? w_valid : 1'b1;
  assign rsp_ready = slv_cyc_wr ? b_ready : r_ready;

  // Slots without a block answer at once
  always_comb
  begin
    slot_ack = '1;
    for (int i = 0; i < `OCL_NUM_SLOTS; i++)
      slot_rdata[i] = `OCL_UNMAPPED_DATA;
    slot_ack[0]   = slot0.ack;
    slot_rdata[0] = slot0.rdata;
    slot_ack[1]   = slot1.ack;
    slot_rdata[1] = slot1.rdata;
  end

  assign tgt_ack   = sel_hit ? slot_ack[slot_idx] : 1'b1;
  assign tgt_rdata = sel_hit ? slot_rdata[slot_idx] : `OCL_UNMAPPED_DATA;
  assign cyc_done  = (slv_state == SLV_CYC) && req_valid && (tgt_ack || tmr_expired);
  assign cyc_end   = cyc_done && !flr;

  always_comb
  begin
    slv_state_nxt = slv_state;
    if (flr)
      slv_state_nxt = SLV_IDLE;
    else
    begin
      case (slv_state)
        SLV_IDLE:
        begin
          if (aw_valid)
            slv_state_nxt = SLV_WR_ADDR;
          else if (ar_valid)
            slv_state_nxt = SLV_CYC;
        end
        SLV_WR_ADDR: slv_state_nxt = SLV_CYC;
        SLV_CYC:
        begin
          if (cyc_done)
            slv_state_nxt = SLV_RESP;
        end
        SLV_RESP:
        begin
          if (rsp_ready)
            slv_state_nxt = SLV_IDLE;
        end
        default: slv_state_nxt = SLV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      slv_state  <= SLV_IDLE;
      slv_cyc_wr <= 1'b0;
    end
    else
    begin
      slv_state <= slv_state_nxt;
      if (slv_state == SLV_IDLE)
        slv_cyc_wr <= aw_valid;
    end

  // Winning address, write side first
  always_ff @(posedge clk)
    if (slv_state == SLV_IDLE)
      slv_addr <= aw_valid ? aw_addr : ar_addr;

  // ------------------------------
  // Strobes
  // ------------------------------
  assign strobe_go = (slv_state == SLV_CYC) && req_valid && !did_req && !flr;

  always_ff @(posedge clk)
    if (!sync_rst_n)
      did_req <= 1'b0;
    else if (slv_state == SLV_IDLE)
      did_req <= 1'b0;
    else if (strobe_go)
      did_req <= 1'b1;

  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      strb_wr <= '0;
      strb_rd <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_MAPPED; i++)
      begin
        strb_wr[i] <= strobe_go && slv_cyc_wr && (slv_sel == i);
        strb_rd[i] <= strobe_go && !slv_cyc_wr && (slv_sel == i);
      end
    end

  always_ff @(posedge clk)
    if (strobe_go)
    begin
      bus_addr  <= slv_addr;
      bus_wdata <= w_data.data;
      bus_wstrb <= w_data.strb;
    end

  assign tmr_start = |{strb_wr, strb_rd};
  assign tmr_clear = cyc_done || flr;

  // ------------------------------
  // Handshakes and response
  // ------------------------------
  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      ar_ready <= 1'b0;
    end
    else
    begin
      aw_ready <= (slv_state_nxt == SLV_WR_ADDR);
      w_ready  <= cyc_end && slv_cyc_wr;
      ar_ready <= cyc_end && !slv_cyc_wr;
    end

  // An ack in the expiry cycle still counts
  always_ff @(posedge clk)
    if (cyc_done)
    begin
      rsp_q   <= tgt_ack ? OKAY : SLVERR;
      rdata_q <= tgt_ack ? tgt_rdata : `OCL_UNMAPPED_DATA;
    end

  assign b_data.resp = rsp_q;
  assign b_valid     = (slv_state == SLV_RESP) && slv_cyc_wr;
  assign r_data.data = rdata_q;
  assign r_data.resp = rsp_q;
  assign r_valid     = (slv_state == SLV_RESP) && !slv_cyc_wr;

  assign slot0.addr  = bus_addr;
  assign slot0.wdata = bus_wdata;
  assign slot0.wstrb = bus_wstrb;
  assign slot0.wr    = strb_wr[0];
  assign slot0.rd    = strb_rd[0];
  assign slot1.addr  = bus_addr;
  assign slot1.wdata = bus_wdata;
  assign slot1.wstrb = bus_wstrb;
  assign slot1.wr    = strb_wr[1];
  assign slot1.rd    = strb_rd[1];

endmodule

/* rtl/ocl_ack_timer.sv */
/*
 * Acknowledge timer
 * Counts from the cycle after a strobe and flags a target that has
 * not answered within the timeout
 */
`timescale 1ns/1ps
`include "ocl_dec_consts.svh"

module ocl_ack_timer (
  input  logic clk,
  input  logic sync_rst_n,
  input  logic start,
  input  logic clear,
  output logic expired
);

  localparam int CW = $clog2(`OCL_ACK_TIMEOUT + 1);

  logic [CW-1:0] cnt;
  logic          armed;

  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      armed   <= 1'b0;
      cnt     <= '0;
      expired <= 1'b0;
    end
    else if (clear)
    begin
      armed   <= 1'b0;
      cnt     <= '0;
      expired <= 1'b0;
    end
    else if (start)
    begin
      armed <= 1'b1;
      cnt   <= '0;
    end
    // Saturates at the timeout, expired holds until clear
    else if (armed && (cnt != CW'(`OCL_ACK_TIMEOUT)))
    begin
      cnt <= cnt + 1'b1;
      if (cnt == CW'(`OCL_ACK_TIMEOUT - 1))
        expired <= 1'b1;
    end

endmodule

/* rtl/cfg_scratch_regs.sv */
/*
 * Scratch register block
 * Three byte-writable scratch words and a read-only identity word on a
 * configuration bus, acknowledged ACK_DELAY cycles after the strobe
 */
`timescale 1ns/1ps

module cfg_scratch_regs #(
  parameter int                    ACK_DELAY = 0,
  parameter ocl_cfg_pkg::cfg_word_t BLOCK_ID  = '0
) (
  input  logic     clk,
  input  logic     sync_rst_n,
  cfg_bus_if.slave cfg
);
  import ocl_cfg_pkg::*;

  localparam int NUM_SCRATCH = 3;
  localparam int DW          = (ACK_DELAY < 2) ? 1 : $clog2(ACK_DELAY + 1);

  cfg_word_t     scratch [NUM_SCRATCH];
  logic [1:0]    reg_idx;
  logic          reg_hit;
  logic          strobe_hit;
  logic          pend;
  logic [DW-1:0] dly_cnt;

  // Offsets 0x10 and up never answer
  assign reg_idx    = cfg.addr[3:2];
  assign reg_hit    = (cfg.addr[7:4] == 4'h0);
  assign strobe_hit = reg_hit && (cfg.wr || cfg.rd);

  always_ff @(posedge clk)
    if (!sync_rst_n)
      scratch <= '{default: '0};
    else if (cfg.wr && reg_hit)
    begin
      for (int r = 0; r < NUM_SCRATCH; r++)
        for (int b = 0; b < 4; b++)
          if ((reg_idx == r) && cfg.wstrb[b])
            scratch[r][8*b +: 8] <= cfg.wdata[8*b +: 8];
    end

  always_comb
  begin
    case (reg_idx)
      2'd0:    cfg.rdata = scratch[0];
      2'd1:    cfg.rdata = scratch[1];
      2'd2:    cfg.rdata = scratch[2];
      default: cfg.rdata = BLOCK_ID;
    endcase
  end

  // ------------------------------
  // Acknowledge delay
  // ------------------------------
  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      pend    <= 1'b0;
      dly_cnt <= '0;
    end
    else if (strobe_hit && (ACK_DELAY != 0))
    begin
      pend    <= 1'b1;
      dly_cnt <= DW'(ACK_DELAY);
    end
    else if (pend)
    begin
      dly_cnt <= dly_cnt - 1'b1;
      if (dly_cnt == DW'(1))
        pend <= 1'b0;
    end

  // Zero delay answers in the strobe cycle
  assign cfg.ack = (ACK_DELAY == 0) ? strobe_hit : (pend && (dly_cnt == DW'(1)));

endmodule

/* rtl/ocl_dec_top.sv */
/*
 * OCL register-access decoder
 * AXI-Lite slave with a register slice on every channel, a transaction
 * state machine, an acknowledge timer and two scratch register blocks
 * in slots 0 and 1
 */
`timescale 1ns/1ps

module ocl_dec_top (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  logic                     flr,
  input  ocl_axil_pkg::axil_addr_t s_awaddr,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic [31:0]              s_wdata,
  input  logic [3:0]               s_wstrb,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  output ocl_axil_pkg::axil_resp_t s_bresp,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  input  ocl_axil_pkg::axil_addr_t s_araddr,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  output logic [31:0]              s_rdata,
  output ocl_axil_pkg::axil_resp_t s_rresp,
  output logic                     s_rvalid,
  input  logic                     s_rready
);
  import ocl_axil_pkg::*;

  axil_addr_t aw_q_addr;
  logic       aw_q_valid;
  logic       aw_q_ready;
  axil_w_t    w_in;
  axil_w_t    w_q;
  logic       w_q_valid;
  logic       w_q_ready;
  axil_addr_t ar_q_addr;
  logic       ar_q_valid;
  logic       ar_q_ready;
  axil_b_t    b_d;
  axil_b_t    b_s;
  logic       b_d_valid;
  logic       b_d_ready;
  axil_r_t    r_d;
  axil_r_t    r_s;
  logic       r_d_valid;
  logic       r_d_ready;
  logic       tmr_start;
  logic       tmr_clear;
  logic       tmr_expired;

  cfg_bus_if slot0_bus ();
  cfg_bus_if slot1_bus ();

  assign w_in.data = s_wdata;
  assign w_in.strb = s_wstrb;
  assign s_bresp   = b_s.resp;
  assign s_rdata   = r_s.data;
  assign s_rresp   = r_s.resp;

  // ------------------------------
  // Channel slices
  // ------------------------------
  axil_chan_slice #(.payload_t(axil_addr_t)) aw_slc (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_data(s_awaddr), .in_valid(s_awvalid), .in_ready(s_awready),
    .out_data(aw_q_addr), .out_valid(aw_q_valid), .out_ready(aw_q_ready)
  );

  axil_chan_slice #(.payload_t(axil_w_t)) w_slc (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_data(w_in), .in_valid(s_wvalid), .in_ready(s_wready),
    .out_data(w_q), .out_valid(w_q_valid), .out_ready(w_q_ready)
  );

  axil_chan_slice #(.payload_t(axil_addr_t)) ar_slc (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_data(s_araddr), .in_valid(s_arvalid), .in_ready(s_arready),
    .out_data(ar_q_addr), .out_valid(ar_q_valid), .out_ready(ar_q_ready)
  );

  axil_chan_slice #(.payload_t(axil_b_t)) b_slc (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_data(b_d), .in_valid(b_d_valid), .in_ready(b_d_ready),
    .out_data(b_s), .out_valid(s_bvalid), .out_ready(s_bready)
  );

  axil_chan_slice #(.payload_t(axil_r_t)) r_slc (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .in_data(r_d), .in_valid(r_d_valid), .in_ready(r_d_ready),
    .out_data(r_s), .out_valid(s_rvalid), .out_ready(s_rready)
  );

  // ------------------------------
  // Decoder core
  // ------------------------------
  ocl_slv_fsm slv_fsm (
    .clk(clk), .sync_rst_n(sync_rst_n), .flr(flr),
    .aw_addr(aw_q_addr), .aw_valid(aw_q_valid), .aw_ready(aw_q_ready),
    .w_data(w_q), .w_valid(w_q_valid), .w_ready(w_q_ready),
    .ar_addr(ar_q_addr), .ar_valid(ar_q_valid), .ar_ready(ar_q_ready),
    .b_data(b_d), .b_valid(b_d_valid), .b_ready(b_d_ready),
    .r_data(r_d), .r_valid(r_d_valid), .r_ready(r_d_ready),
    .tmr_start(tmr_start), .tmr_clear(tmr_clear), .tmr_expired(tmr_expired),
    .slot0(slot0_bus.master), .slot1(slot1_bus.master)
  );

  ocl_ack_timer ack_tmr (
    .clk(clk), .sync_rst_n(sync_rst_n),
    .start(tmr_start), .clear(tmr_clear), .expired(tmr_expired)
  );

  // Slot 1 answers three cycles after slot 0
  cfg_scratch_regs #(.ACK_DELAY(0), .BLOCK_ID(32'h0cf6_0000)) slot0_regs (
    .clk(clk), .sync_rst_n(sync_rst_n), .cfg(slot0_bus.slave)
  );

  cfg_scratch_regs #(.ACK_DELAY(3), .BLOCK_ID(32'h0cf6_0001)) slot1_regs (
    .clk(clk), .sync_rst_n(sync_rst_n), .cfg(slot1_bus.slave)
  );

endmodule

/* bench/ocl_dec_properties.sv */
/*
 * OCL decoder port properties
 * AXI-Lite handshake rules checked at the decoder's top-level ports
 */
`timescale 1ns/1ps

module ocl_dec_properties (
  input logic                     clk,
  input logic                     sync_rst_n,
  input logic                     s_awvalid,
  input logic                     s_awready,
  input logic                     s_wready,
  input logic                     s_arvalid,
  input logic                     s_arready,
  input logic                     s_bvalid,
  input logic                     s_bready,
  input ocl_axil_pkg::axil_resp_t s_bresp,
  input logic                     s_rvalid,
  input logic                     s_rready,
  input logic [31:0]              s_rdata,
  input ocl_axil_pkg::axil_resp_t s_rresp
);

  int unsigned wr_open;
  int unsigned rd_open;

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // Requests accepted but not yet answered
  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      wr_open <= 0;
      rd_open <= 0;
    end
    else
    begin
      wr_open <= wr_open + 32'(s_awvalid && s_awready) - 32'(s_bvalid && s_bready);
      rd_open <= rd_open + 32'(s_arvalid && s_arready) - 32'(s_rvalid && s_rready);
    end

  b_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
    else
    begin
      $error("B channel changed before its handshake");
      fail_cnt++;
    end

  r_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
    else
    begin
      $error("R channel changed before its handshake");
      fail_cnt++;
    end

  quiet_after_reset: assert property (@(posedge clk)
    !sync_rst_n |=> !s_bvalid && !s_rvalid && !s_awready && !s_wready && !s_arready)
    else
    begin
      $error("Output valid or ready high right after reset");
      fail_cnt++;
    end

  b_needs_req: assert property (@(posedge clk) disable iff (!sync_rst_n)
    s_bvalid |-> wr_open != 0)
    else
    begin
      $error("Write response without a write request");
      fail_cnt++;
    end

  r_needs_req: assert property (@(posedge clk) disable iff (!sync_rst_n)
    s_rvalid |-> rd_open != 0)
    else
    begin
      $error("Read response without a read request");
      fail_cnt++;
    end

endmodule

/* bench/ocl_dec_tb.sv */
/*
 * OCL decoder testbench
 * Table-driven AXI-Lite accesses to scratch, identity, unmapped and
 * missing registers, with LFSR data, response back-pressure and an
 * flr pulse during a stalled read
 */
`timescale 1ns/1ps
`include "ocl_dec_consts.svh"

module ocl_dec_tb;
  import ocl_axil_pkg::*;
  import ocl_cfg_pkg::*;

  typedef enum {OP_WR, OP_RD, OP_FLR_RD} op_e;

  typedef struct {
    string      name;
    op_e        op;
    axil_addr_t addr;
    cfg_word_t  wdata;
    cfg_strb_t  strb;
    cfg_word_t  exp_data;
    axil_resp_t exp_resp;
    int         bp;
  } entry_t;

  logic       clk;
  logic       sync_rst_n;
  logic       flr;
  axil_addr_t s_awaddr;
  logic       s_awvalid;
  logic       s_awready;
  cfg_word_t  s_wdata;
  cfg_strb_t  s_wstrb;
  logic       s_wvalid;
  logic       s_wready;
  axil_resp_t s_bresp;
  logic       s_bvalid;
  logic       s_bready;
  axil_addr_t s_araddr;
  logic       s_arvalid;
  logic       s_arready;
  cfg_word_t  s_rdata;
  axil_resp_t s_rresp;
  logic       s_rvalid;
  logic       s_rready;

  entry_t     tbl[$];
  entry_t     e;
  logic       tbl_ready;
  logic [31:0] lfsr;
  cfg_word_t  shadow [2][3];
  cfg_word_t  rd_data;
  axil_resp_t rsp;
  int         n_mismatch;
  int         n_fail;

  ocl_dec_top DUT (.*);

  bind ocl_dec_top ocl_dec_properties props (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // Models and stimulus helpers
  // ------------------------------
  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'hd000_0001 : 32'h0);
      val  = {val[30:0], b};
    end
    return val;
  endfunction

  function automatic cfg_word_t merge_bytes(cfg_word_t old_w, cfg_word_t new_w,
                                            cfg_strb_t strb);
    cfg_word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  function automatic axil_addr_t slot_addr(int slot, int off);
    return (axil_addr_t'(slot) << `OCL_SLOT_LSB) | axil_addr_t'(off);
  endfunction

  function automatic void add_entry(string name, op_e op, axil_addr_t addr,
                                    cfg_word_t wdata, cfg_strb_t strb,
                                    cfg_word_t exp_data, axil_resp_t exp_resp, int bp);
    entry_t n;
    n.name     = name;
    n.op       = op;
    n.addr     = addr;
    n.wdata    = wdata;
    n.strb     = strb;
    n.exp_data = exp_data;
    n.exp_resp = exp_resp;
    n.bp       = bp;
    tbl.push_back(n);
  endfunction

  task automatic build_table();
    int        s;
    int        r;
    int        k;
    cfg_word_t d;
    cfg_word_t id;
    cfg_strb_t part_strb [4];
    int        far_slot [4];
    part_strb = '{4'h1, 4'h6, 4'h8, 4'ha};
    far_slot  = '{2, 3, 4, 15};
    for (s = 0; s < 2; s++)
      for (r = 0; r < 3; r++)
      begin
        d = rand_bits(32);
        shadow[s][r] = d;
        add_entry($sformatf("wr s%0d r%0d", s, r), OP_WR, slot_addr(s, 4*r), d, 4'hf,
                  '0, OKAY, 0);
        add_entry($sformatf("rd s%0d r%0d", s, r), OP_RD, slot_addr(s, 4*r), '0, 4'h0,
                  shadow[s][r], OKAY, 0);
      end
    // Byte lanes outside the strobe keep their old value
    for (k = 0; k < 4; k++)
    begin
      s = k % 2;
      r = k % 3;
      d = rand_bits(32);
      shadow[s][r] = merge_bytes(shadow[s][r], d, part_strb[k]);
      add_entry($sformatf("wr part %0d", k), OP_WR, slot_addr(s, 4*r), d, part_strb[k],
                '0, OKAY, 0);
      add_entry($sformatf("rd part %0d", k), OP_RD, slot_addr(s, 4*r), '0, 4'h0,
                shadow[s][r], OKAY, 0);
    end
    for (s = 0; s < 2; s++)
    begin
      id = 32'h0cf6_0000 | s;
      add_entry($sformatf("id s%0d", s), OP_RD, slot_addr(s, 'h0c), '0, 4'h0, id, OKAY, 0);
      add_entry($sformatf("id wr s%0d", s), OP_WR, slot_addr(s, 'h0c), rand_bits(32), 4'hf,
                '0, OKAY, 0);
      add_entry($sformatf("id again s%0d", s), OP_RD, slot_addr(s, 'h0c), '0, 4'h0, id,
                OKAY, 0);
    end
    for (k = 0; k < 4; k++)
    begin
      add_entry($sformatf("wr slot %0d", far_slot[k]), OP_WR, slot_addr(far_slot[k], 4),
                rand_bits(32), 4'hf, '0, OKAY, 0);
      add_entry($sformatf("rd slot %0d", far_slot[k]), OP_RD, slot_addr(far_slot[k], 4),
                '0, 4'h0, `OCL_UNMAPPED_DATA, OKAY, 0);
    end
    // No register answers here, so the timer ends the access
    add_entry("wr no ack", OP_WR, slot_addr(0, 'h10), 32'h1234_5678, 4'hf, '0, SLVERR, 0);
    add_entry("rd no ack", OP_RD, slot_addr(0, 'h10), '0, 4'h0, `OCL_UNMAPPED_DATA, SLVERR, 0);
    add_entry("rd no ack hi", OP_RD, slot_addr(0, 'hfc), '0, 4'h0, `OCL_UNMAPPED_DATA,
              SLVERR, 0);
    for (k = 0; k < 8; k++)
    begin
      s = rand_bits(1);
      r = rand_bits(2) % 3;
      d = rand_bits(32);
      shadow[s][r] = d;
      add_entry($sformatf("bp wr %0d", k), OP_WR, slot_addr(s, 4*r), d, 4'hf, '0, OKAY,
                rand_bits(4));
      add_entry($sformatf("bp rd %0d", k), OP_RD, slot_addr(s, 4*r), '0, 4'h0, d, OKAY,
                rand_bits(4));
    end
    add_entry("flr rd", OP_FLR_RD, slot_addr(0, 'h10), '0, 4'h0, `OCL_UNMAPPED_DATA,
              SLVERR, 0);
    d = rand_bits(32);
    add_entry("wr after flr", OP_WR, slot_addr(0, 8), d, 4'hf, '0, OKAY, 0);
    add_entry("rd after flr", OP_RD, slot_addr(0, 8), '0, 4'h0, d, OKAY, 0);
  endtask

  // ------------------------------
  // Bus tasks entered on a falling edge
  // ------------------------------
  task automatic do_write(input axil_addr_t addr, input cfg_word_t data,
                          input cfg_strb_t strb, input int bp, output axil_resp_t resp);
    logic aw_go;
    logic w_go;
    s_awaddr  = addr;
    s_awvalid = 1'b1;
    s_wdata   = data;
    s_wstrb   = strb;
    s_wvalid  = 1'b1;
    while (s_awvalid || s_wvalid)
    begin
      aw_go = s_awvalid && s_awready;
      w_go  = s_wvalid && s_wready;
      @(negedge clk);
      if (aw_go)
        s_awvalid = 1'b0;
      if (w_go)
        s_wvalid = 1'b0;
    end
    while (!s_bvalid)
      @(negedge clk);
    repeat (bp) @(negedge clk);
    resp     = s_bresp;
    s_bready = 1'b1;
    @(negedge clk);
    s_bready = 1'b0;
  endtask

  task automatic do_read(input axil_addr_t addr, input int bp,
                         output cfg_word_t data, output axil_resp_t resp);
    logic ar_go;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    while (s_arvalid)
    begin
      ar_go = s_arready;
      @(negedge clk);
      if (ar_go)
        s_arvalid = 1'b0;
    end
    while (!s_rvalid)
      @(negedge clk);
    repeat (bp) @(negedge clk);
    data     = s_rdata;
    resp     = s_rresp;
    s_rready = 1'b1;
    @(negedge clk);
    s_rready = 1'b0;
  endtask

  // Lands while the decoder waits on the missing register
  task automatic pulse_flr();
    repeat (6) @(negedge clk);
    flr = 1'b1;
    repeat (2) @(negedge clk);
    flr = 1'b0;
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp)
    begin
      n_mismatch++;
      $display("** Error: %s: resp expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input cfg_word_t exp, input cfg_word_t act);
    if (act !== exp)
    begin
      n_mismatch++;
      $display("** Error: %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    sync_rst_n = 1'b0;
    flr        = 1'b0;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wstrb    = '0;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    n_mismatch = 0;
    n_fail     = 0;
    tbl_ready  = 1'b0;
    lfsr       = 32'h9319_1229;
    shadow     = '{default: '0};
    build_table();
    tbl_ready = 1'b1;
    repeat (3) @(negedge clk);
    sync_rst_n = 1'b1;
    foreach (tbl[i])
    begin
      e = tbl[i];
      case (e.op)
        OP_WR:
        begin
          do_write(e.addr, e.wdata, e.strb, e.bp, rsp);
          check_resp(e.name, e.exp_resp, rsp);
        end
        OP_RD:
        begin
          do_read(e.addr, e.bp, rd_data, rsp);
          check_resp(e.name, e.exp_resp, rsp);
          check_data(e.name, e.exp_data, rd_data);
        end
        default:
        begin
          fork
            do_read(e.addr, e.bp, rd_data, rsp);
            pulse_flr();
          join
          check_resp(e.name, e.exp_resp, rsp);
          check_data(e.name, e.exp_data, rd_data);
          // The reset access must not answer a second time
          repeat (`OCL_ACK_TIMEOUT + 8)
          begin
            @(negedge clk);
            if (s_rvalid)
            begin
              n_fail++;
              $display("%s: a second read response came after flr", e.name);
            end
          end
        end
      endcase
    end
    repeat (4) @(negedge clk);
    n_fail += DUT.props.fail_cnt;
    $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
    if ((n_mismatch == 0) && (n_fail == 0))
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    int limit;
    wait (tbl_ready);
    limit = tbl.size() * 60 + 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog: the run did not finish within %0d cycles", limit);
    $display("Errors: %0d mismatches, %0d other failures", n_mismatch,
             n_fail + DUT.props.fail_cnt + 1);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* ocl_dec.f */
+incdir+rtl
rtl/ocl_axil_pkg.sv
rtl/ocl_cfg_pkg.sv
rtl/cfg_bus_if.sv
rtl/axil_chan_slice.sv
rtl/ocl_slv_fsm.sv
rtl/ocl_ack_timer.sv
rtl/cfg_scratch_regs.sv
rtl/ocl_dec_top.sv
bench/ocl_dec_properties.sv
bench/ocl_dec_tb.sv

/* Makefile */
# Verilator build and run for the OCL register-access decoder

VERILATOR ?= verilator
TOP       ?= ocl_dec_tb
FILELIST  ?= ocl_dec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the exit code of the simulator
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
